//--- Makefile
# Verilator build and run of the exeCore testbench

VERILATOR ?= verilator
TOP       ?= exeCoreTb
FLIST     ?= flist.f
BUILDDIR  ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST RESULT: PASS
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILDDIR) and $(LOG)"
	@echo "  help   list these targets"
	@echo "variables: VERILATOR TOP FLIST BUILDDIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILDDIR) -o V$(TOP)
	-./$(BUILDDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(BUILDDIR) $(LOG)

//--- flist.f
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/instrDecode.sv
verilog/pipeReg.sv
verilog/execUnit.sv
verilog/exeCore.sv
tb/exeCoreTb.sv

//--- tb/exeCoreTb.sv
// ##################################################
// exeCore testbench with clock, reset and random
// stimulus, reference model, in-order compare
// and watchdog
// ##################################################

`timescale 1ns/100ps

module exeCoreTb
    import isaPkg::*;
;

    localparam int clkPeriod   = 8;
    localparam int resetCycles = 8;
    localparam int numAlu      = 300;
    localparam int numBranch   = 120;
    localparam int numStall    = 150;
    localparam int numFlush    = 120;
    localparam int numNonWrite = 60;
    localparam int numPlanned  = numAlu + numBranch + numStall + numFlush + numNonWrite;
    localparam int limitCycles = numPlanned * 20 + resetCycles + 100;   // drains and idle

    localparam logic [5:0] rFuncs [8]    = '{fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnSlt,
                                             fnSll, fnSrl};
    localparam logic [5:0] iOps [6]      = '{opAddiu, opSlti, opAndi, opOri, opXori, opLui};
    localparam logic [5:0] brOps [4]     = '{opBeq, opBne, opJ, opJal};
    // REGIMM, ADDI, LW and SW
    localparam logic [5:0] unknownOps [4] = '{6'h01, 6'h08, 6'h23, 6'h2b};

    // prediction for one accepted instruction
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        regWrite;
        logic [4:0]  dst;
        logic [31:0] result;
        logic        brTaken;
        logic [31:0] brTarget;
        logic [31:0] accEdge;       // edge of acceptance
        logic [31:0] stallMark;     // stall edges seen before acceptance
    } expectT;

    logic        clk;
    logic        rst;
    logic        stall;
    logic        flush;
    logic        idValid;
    logic [31:0] idInstr;
    logic [31:0] idPc;
    logic [31:0] idBusA;
    logic [31:0] idBusB;
    logic        wbValid;
    logic [31:0] wbPc;
    logic        wbRegWrite;
    logic [4:0]  wbDst;
    logic [31:0] wbData;
    logic        wbBrTaken;
    logic [31:0] wbBrTarget;

    expectT      expQ[$];
    string       testName;
    logic [31:0] edgeCount;
    logic [31:0] stallCount;

    exeCore i_dut (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .flush      (flush),
        .idValid    (idValid),
        .idInstr    (idInstr),
        .idPc       (idPc),
        .idBusA     (idBusA),
        .idBusB     (idBusB),
        .wbValid    (wbValid),
        .wbPc       (wbPc),
        .wbRegWrite (wbRegWrite),
        .wbDst      (wbDst),
        .wbData     (wbData),
        .wbBrTaken  (wbBrTaken),
        .wbBrTarget (wbBrTarget)
    );

    always #(clkPeriod / 2) clk = ~clk;

    task automatic checkValue(input string field, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED: test %s, %s expected %h actual %h",
                     testName, field, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic expectT predictResult(input logic [31:0] instr, input logic [31:0] pc,
                                             input logic [31:0] a, input logic [31:0] b);
        expectT      e;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [31:0] pc4;
        logic [4:0]  sh;
        e          = '0;
        sext       = {{16{instr[15]}}, instr[15:0]};
        zext       = {16'h0000, instr[15:0]};
        pc4        = pc + 32'd4;
        sh         = instr[10:6];
        e.valid    = 1'b1;
        e.pc       = pc;
        e.regWrite = 1'b1;
        e.dst      = instr[20:16];      // rt unless R-type or JAL
        case (instr[31:26])
            opSpecial: begin
                e.dst = instr[15:11];
                case (instr[5:0])
                    fnAddu:  e.result = a + b;
                    fnSubu:  e.result = a - b;
                    fnAnd:   e.result = a & b;
                    fnOr:    e.result = a | b;
                    fnXor:   e.result = a ^ b;
                    fnSlt:   e.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    fnSll:   e.result = b << sh;
                    fnSrl:   e.result = b >> sh;
                    default: e.valid = 1'b0;
                endcase
            end
            opAddiu: e.result = a + sext;
            opSlti:  e.result = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
            opAndi:  e.result = a & zext;
            opOri:   e.result = a | zext;
            opXori:  e.result = a ^ zext;
            opLui:   e.result = {instr[15:0], 16'h0000};
            opBeq, opBne: begin
                e.regWrite = 1'b0;
                e.brTaken  = (instr[31:26] == opBeq) ? (a == b) : (a != b);
                e.brTarget = pc4 + (sext << 2);
            end
            opJ, opJal: begin
                e.regWrite = (instr[31:26] == opJal);
                e.dst      = 5'd31;
                e.result   = pc + 32'd8;   // link value
                e.brTaken  = 1'b1;
                e.brTarget = {pc4[31:28], instr[25:0], 2'b00};
            end
            default: e.valid = 1'b0;
        endcase
        if (e.dst == 5'd0) begin
            e.regWrite = 1'b0;
        end
        if (!e.valid) begin
            e = '0;
        end
        return e;
    endfunction

    function automatic logic [31:0] randAluInstr();
        logic [31:0] w;
        w = $urandom;
        if ($urandom_range(1) == 0) begin
            w[31:26] = opSpecial;
            w[5:0]   = rFuncs[$urandom_range(7)];
        end else begin
            w[31:26] = iOps[$urandom_range(5)];
        end
        return w;
    endfunction

    function automatic logic [31:0] randBranchInstr();
        logic [31:0] w;
        w        = $urandom;
        w[31:26] = brOps[$urandom_range(3)];
        return w;
    endfunction

    // present one instruction and keep it steady until the DUT takes it
    task automatic issueInstr(input logic valid, input logic [31:0] instr, input logic [31:0] a,
                              input logic [31:0] b, input int stallPct, input int flushPct);
        logic accepted;
        accepted = 1'b0;
        @(negedge clk);
        idValid <= valid;
        idInstr <= instr;
        idPc    <= $urandom & 32'hffff_fffc;
        idBusA  <= a;
        idBusB  <= b;
        while (!accepted) begin
            stall <= ($urandom_range(99) < stallPct);
            flush <= ($urandom_range(99) < flushPct);
            @(posedge clk);
            accepted = !stall && !flush;
            if (!accepted) begin
                @(negedge clk);
            end
        end
    endtask

    task automatic drainPipe();
        int waited;
        waited = 0;
        @(negedge clk);
        idValid <= 1'b0;
        stall   <= 1'b0;
        flush   <= 1'b0;
        while (expQ.size() != 0 && waited < 10) begin
            @(negedge clk);
            waited++;
        end
    endtask

    // compare process that also tracks acceptance, stalls and flushes
    always @(posedge clk) begin : compare
        expectT want;
        if (rst) begin
            edgeCount  <= '0;
            stallCount <= '0;
        end else begin
            if (wbValid) begin
                if (expQ.size() == 0) begin
                    $display("ERROR: test %s, a result appeared that no instruction should give",
                             testName);
                    $display("TEST RESULT: FAIL");
                    $fatal(1, "unexpected result");
                end else begin
                    want = expQ.pop_front();
                    checkValue("pc", want.pc, wbPc);
                    checkValue("regWrite", 32'(want.regWrite), 32'(wbRegWrite));
                    checkValue("brTaken", 32'(want.brTaken), 32'(wbBrTaken));
                    checkValue("latency", want.accEdge + 32'd2 + stallCount - want.stallMark,
                               edgeCount);
                    if (want.regWrite) begin
                        checkValue("dst", 32'(want.dst), 32'(wbDst));
                        checkValue("result", want.result, wbData);
                    end
                    if (want.brTaken) begin
                        checkValue("brTarget", want.brTarget, wbBrTarget);
                    end
                end
            end
            if (flush) begin
                expQ.delete();                  // in-flight work is dropped
            end else if (!stall && idValid) begin
                want = predictResult(idInstr, idPc, idBusA, idBusB);
                if (want.valid) begin
                    want.accEdge   = edgeCount;
                    want.stallMark = stallCount;
                    expQ.push_back(want);
                end
            end
            if (stall) begin
                stallCount <= stallCount + 32'd1;
            end
            edgeCount <= edgeCount + 32'd1;
        end
    end

    initial begin : watchdog
        #(limitCycles * clkPeriod);
        $display("ERROR: run exceeded %0d cycles, the pipeline seems to hang", limitCycles);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

    initial begin : stimulus
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        void'($urandom(12));
        clk      = 1'b0;
        rst      = 1'b1;
        stall    = 1'b0;
        flush    = 1'b0;
        idValid  = 1'b0;
        idInstr  = '0;
        idPc     = '0;
        idBusA   = '0;
        idBusB   = '0;
        testName = "reset";
        repeat (resetCycles) @(negedge clk);
        rst <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            checkValue("wbValid", 32'd0, 32'(wbValid));
            checkValue("wbPc", 32'd0, wbPc);
            checkValue("wbRegWrite", 32'd0, 32'(wbRegWrite));
            checkValue("wbDst", 32'd0, 32'(wbDst));
            checkValue("wbData", 32'd0, wbData);
            checkValue("wbBrTaken", 32'd0, 32'(wbBrTaken));
            checkValue("wbBrTarget", 32'd0, wbBrTarget);
        end

        testName = "alu";
        repeat (numAlu) begin
            issueInstr(1'b1, randAluInstr(), $urandom, $urandom, 0, 0);
        end
        drainPipe();

        testName = "branch";
        repeat (numBranch) begin
            a = $urandom;
            b = ($urandom_range(1) == 0) ? a : $urandom;   // equal and unequal
            issueInstr(1'b1, randBranchInstr(), a, b, 0, 0);
        end
        drainPipe();

        testName = "stall";
        repeat (numStall) begin
            w = ($urandom_range(2) == 0) ? randBranchInstr() : randAluInstr();
            a = $urandom;
            b = ($urandom_range(3) == 0) ? a : $urandom;
            issueInstr(1'b1, w, a, b, 40, 0);
        end
        drainPipe();

        testName = "flush";
        repeat (numFlush) begin
            w = ($urandom_range(2) == 0) ? randBranchInstr() : randAluInstr();
            a = $urandom;
            b = ($urandom_range(3) == 0) ? a : $urandom;
            issueInstr(1'b1, w, a, b, 20, 15);
        end
        drainPipe();

        testName = "nonwrite";
        repeat (numNonWrite) begin
            w = randAluInstr();
            case ($urandom_range(2))
                0: w[31:26] = unknownOps[$urandom_range(3)];
                1: begin
                    if (w[31:26] == opSpecial) begin
                        w[15:11] = 5'd0;    // rd
                    end else begin
                        w[20:16] = 5'd0;    // rt
                    end
                end
                default: ;
            endcase
            issueInstr($urandom_range(3) != 0, w, $urandom, $urandom, 10, 0);
        end
        drainPipe();

        repeat (4) @(negedge clk);              // idle so stray results get flagged
        if (expQ.size() != 0) begin
            $display("ERROR: %0d expected results never appeared", expQ.size());
            $display("TEST RESULT: FAIL");
            $fatal(1, "missing results");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- verilog/exeCore.sv
// ##################################################
// exeCore: decode, ID/EXE register, execute unit
// and EXE/WB register of the pipeline slice
// ##################################################

`timescale 1ns/100ps

module exeCore
    import pipePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,      // level, holds ID/EXE
    input  logic        flush,      // pulse, clears both stages
    input  logic        idValid,
    input  logic [31:0] idInstr,
    input  logic [31:0] idPc,
    input  logic [31:0] idBusA,
    input  logic [31:0] idBusB,
    output logic        wbValid,
    output logic [31:0] wbPc,
    output logic        wbRegWrite,
    output logic [4:0]  wbDst,
    output logic [31:0] wbData,
    output logic        wbBrTaken,
    output logic [31:0] wbBrTarget
);

    idExePayloadT idPayload;
    idExePayloadT exePayload;
    exeWbPayloadT exeResult;
    exeWbPayloadT wbPayload;

    instrDecode decode (
        .idValid (idValid),
        .idInstr (idInstr),
        .idPc    (idPc),
        .idBusA  (idBusA),
        .idBusB  (idBusB),
        .payload (idPayload)
    );

    pipeReg #(.payloadT(idExePayloadT)) idExeReg (
        .clk   (clk),
        .rst   (rst),
        .hold  (stall),
        .flush (flush),
        .d     (idPayload),
        .q     (exePayload)
    );

    execUnit execute (
        .stall (stall),
        .exe   (exePayload),
        .wb    (exeResult)
    );

    pipeReg #(.payloadT(exeWbPayloadT)) exeWbReg (
        .clk   (clk),
        .rst   (rst),
        .hold  (1'b0),      // loads every cycle
        .flush (flush),
        .d     (exeResult),
        .q     (wbPayload)
    );

    assign wbValid    = wbPayload.valid;
    assign wbPc       = wbPayload.pc;
    assign wbRegWrite = wbPayload.regWrite;
    assign wbDst      = wbPayload.dst;
    assign wbData     = wbPayload.result;
    assign wbBrTaken  = wbPayload.brTaken;
    assign wbBrTarget = wbPayload.brTarget;

endmodule

//--- verilog/execUnit.sv
// ##################################################
// execUnit: ALU and shifter, branch compare,
// branch and jump targets, link value, result select
// ##################################################

`timescale 1ns/100ps

module execUnit
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic         stall,
    input  idExePayloadT exe,
    output exeWbPayloadT wb
);

    logic [31:0] opB;
    logic [31:0] aluResult;
    logic [31:0] pcPlus4;
    logic [31:0] pcPlus8;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic        operandsEqual;
    logic        taken;

    assign opB           = exe.aluSrcB ? exe.imm32 : exe.busB;
    assign pcPlus4       = exe.pc + 32'd4;
    assign pcPlus8       = exe.pc + 32'd8;                  // JAL link value
    assign branchTarget  = pcPlus4 + {exe.imm32[29:0], 2'b00};
    assign jumpTarget    = {pcPlus4[31:28], exe.jumpIndex, 2'b00};
    assign operandsEqual = (exe.busA == exe.busB);

    always_comb begin
        case (exe.aluOp)
            aluAdd:  aluResult = exe.busA + opB;
            aluSub:  aluResult = exe.busA - opB;
            aluAnd:  aluResult = exe.busA & opB;
            aluOr:   aluResult = exe.busA | opB;
            aluXor:  aluResult = exe.busA ^ opB;
            aluSlt:  aluResult = {31'h0, $signed(exe.busA) < $signed(opB)};
            aluSll:  aluResult = exe.busB << exe.shamt;    // shifts use rt
            aluSrl:  aluResult = exe.busB >> exe.shamt;
            aluLui:  aluResult = {opB[15:0], 16'h0000};
            default: aluResult = 32'h0;
        endcase
    end

    always_comb begin
        case (exe.branchKind)
            branchBeq:  taken = operandsEqual;
            branchBne:  taken = !operandsEqual;
            branchJump: taken = 1'b1;
            default:    taken = 1'b0;
        endcase
    end

    always_comb begin
        wb.valid    = exe.valid;
        wb.pc       = exe.pc;
        wb.regWrite = exe.regWrite;
        wb.dst      = exe.dst;
        wb.result   = exe.isLink ? pcPlus8 : aluResult;
        wb.brTaken  = taken;
        case (exe.branchKind)
            branchBeq, branchBne: wb.brTarget = branchTarget;
            branchJump:           wb.brTarget = jumpTarget;
            default:              wb.brTarget = 32'h0;
        endcase
        // held instruction leaves only once, on the cycle stall drops
        if (stall) begin
            wb = '0;
        end
    end

endmodule

//--- verilog/instrDecode.sv
// ##################################################
// instrDecode: instruction word and operands into
// the ID/EXE payload, unknown encodings become bubbles
// ##################################################

`timescale 1ns/100ps

module instrDecode
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic         idValid,
    input  logic [31:0]  idInstr,
    input  logic [31:0]  idPc,
    input  logic [31:0]  idBusA,
    input  logic [31:0]  idBusB,
    output idExePayloadT payload
);

    logic [5:0]  opcode;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  shamt;
    logic [5:0]  funct;
    logic [15:0] imm16;
    logic [25:0] index;

    logic        known;         // supported encoding
    logic        signExt;
    logic        writes;
    logic        isLink;
    logic        aluSrcB;
    aluOpT       aluOp;
    branchKindT  branchKind;
    logic [4:0]  dst;
    logic        decValid;

    assign opcode = idInstr[31:26];
    assign rt     = idInstr[20:16];
    assign rd     = idInstr[15:11];
    assign shamt  = idInstr[10:6];
    assign funct  = idInstr[5:0];
    assign imm16  = idInstr[15:0];
    assign index  = idInstr[25:0];

    always_comb begin
        known      = 1'b1;
        signExt    = 1'b0;
        writes     = 1'b0;
        isLink     = 1'b0;
        aluSrcB    = 1'b0;
        aluOp      = aluAdd;
        branchKind = branchNone;
        dst        = rt;            // I-type default
        case (opcode)
            opSpecial: begin
                dst    = rd;
                writes = 1'b1;
                case (funct)
                    fnAddu:  aluOp = aluAdd;
                    fnSubu:  aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnXor:   aluOp = aluXor;
                    fnSlt:   aluOp = aluSlt;
                    fnSll:   aluOp = aluSll;
                    fnSrl:   aluOp = aluSrl;
                    default: known = 1'b0;
                endcase
            end
            opAddiu: begin
                aluOp   = aluAdd;
                aluSrcB = 1'b1;
                signExt = 1'b1;
                writes  = 1'b1;
            end
            opSlti: begin
                aluOp   = aluSlt;
                aluSrcB = 1'b1;
                signExt = 1'b1;
                writes  = 1'b1;
            end
            opAndi: begin
                aluOp   = aluAnd;
                aluSrcB = 1'b1;
                writes  = 1'b1;
            end
            opOri: begin
                aluOp   = aluOr;
                aluSrcB = 1'b1;
                writes  = 1'b1;
            end
            opXori: begin
                aluOp   = aluXor;
                aluSrcB = 1'b1;
                writes  = 1'b1;
            end
            opLui: begin
                aluOp   = aluLui;
                aluSrcB = 1'b1;
                writes  = 1'b1;
            end
            opBeq: begin
                branchKind = branchBeq;
                signExt    = 1'b1;      // offset for the target
            end
            opBne: begin
                branchKind = branchBne;
                signExt    = 1'b1;
            end
            opJ:     branchKind = branchJump;
            opJal: begin
                branchKind = branchJump;
                isLink     = 1'b1;
                writes     = 1'b1;
                dst        = linkReg;
            end
            default: known = 1'b0;
        endcase
    end

    assign decValid = idValid && known;

    always_comb begin
        payload.valid      = decValid;
        payload.pc         = idPc;
        payload.busA       = idBusA;
        payload.busB       = idBusB;
        payload.imm32      = signExt ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};
        payload.shamt      = shamt;
        payload.aluOp      = aluOp;
        payload.aluSrcB    = aluSrcB;
        payload.branchKind = decValid ? branchKind : branchNone;
        payload.jumpIndex  = index;
        payload.isLink     = isLink;
        payload.regWrite   = decValid && writes && (dst != 5'd0);  // r0 writes dropped here
        payload.dst        = dst;
    end

endmodule

//--- verilog/isaPkg.sv
// ##################################################
// MIPS instruction field values used by the slice
// ALU operation and control-transfer kind enums
// ##################################################

package isaPkg;

    // primary opcodes, instr[31:26]
    localparam logic [5:0] opSpecial = 6'h00;   // R-type, funct selects op
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opJal     = 6'h03;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opSlti    = 6'h0a;
    localparam logic [5:0] opAndi    = 6'h0c;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opXori    = 6'h0e;
    localparam logic [5:0] opLui     = 6'h0f;

    // funct codes for opSpecial, instr[5:0]
    localparam logic [5:0] fnSll     = 6'h00;
    localparam logic [5:0] fnSrl     = 6'h02;
    localparam logic [5:0] fnAddu    = 6'h21;
    localparam logic [5:0] fnSubu    = 6'h23;
    localparam logic [5:0] fnAnd     = 6'h24;
    localparam logic [5:0] fnOr      = 6'h25;
    localparam logic [5:0] fnXor     = 6'h26;
    localparam logic [5:0] fnSlt     = 6'h2a;

    localparam logic [4:0] linkReg   = 5'd31;   // JAL destination

    // zero value is add, so a cleared stage is harmless
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,     // signed compare
        aluSll,
        aluSrl,
        aluLui
    } aluOpT;

    typedef enum logic [1:0] {
        branchNone,
        branchBeq,
        branchBne,
        branchJump  // J and JAL
    } branchKindT;

endpackage

//--- verilog/pipePkg.sv
// ##################################################
// payload of the ID/EXE stage register
// payload of the EXE/WB stage register
// ##################################################

package pipePkg;

    import isaPkg::*;

    // decoded instruction as held between ID and EXE
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] busA;          // rs operand
        logic [31:0] busB;          // rt operand
        logic [31:0] imm32;         // already extended
        logic [4:0]  shamt;
        aluOpT       aluOp;
        logic        aluSrcB;       // 1 selects imm32
        branchKindT  branchKind;
        logic [25:0] jumpIndex;
        logic        isLink;        // JAL, result is pc+8
        logic        regWrite;      // never set for dst 0
        logic [4:0]  dst;
    } idExePayloadT;

    // executed result as presented at the ports
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        regWrite;
        logic [4:0]  dst;
        logic [31:0] result;
        logic        brTaken;
        logic [31:0] brTarget;
    } exeWbPayloadT;

endpackage

//--- verilog/pipeReg.sv
// ##################################################
// pipeReg: stage register over any payload type
// clears on reset or flush, holds, else loads
// ##################################################

`timescale 1ns/100ps

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    hold,       // keep current contents
    input  logic    flush,      // wins over hold
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            q <= '0;            // all-zero payload is a bubble
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule
